/* core_trace.txt */
# I <instruction hex> <expected bresp>, D drains until status reads zero,
# E <register> <expected hex value>; lines starting with # are skipped.
# independent immediates and lui
I 06400093 0
I ff900113 0
I 123451b7 0
I 5a504213 0
I 0f006293 0
D
# register ops on retired sources, plus srai
I 00208333 0
I 402083b3 0
I 0020f433 0
I 004095b3 0
I 00415633 0
I 404156b3 0
I 00112733 0
I 001137b3 0
I 40115893 0
D
E 3 12345000
E 4 000005a5
E 5 000000f0
E 6 0000005d
E 7 0000006b
E 8 00000060
E 11 00000c80
E 12 07ffffff
E 13 ffffffff
E 14 00000001
E 15 00000000
E 17 fffffffc
# dependency chain, write-after-write and x0
I 00500a13 0
I 014a0ab3 0
I 002a9a93 0
I 414a8b33 0
I 00100b93 0
I 003b8b93 0
I 00900b93 0
I 03708013 0
D
E 20 00000005
E 21 00000028
E 22 00000023
E 23 00000009
E 0 00000000
# load, branch and mul are rejected
I 0000ac03 2
I 00208463 2
I 02208c33 2
D
E 24 00000000
E 1 00000064
# burst longer than the rob
I 00100c93 0
I 001c8c93 0
I 001c8c93 0
I 001c8c93 0
I 001c8c93 0
I 001c8c93 0
I 001c8c93 0
I 001c8c93 0
I 019c8d33 0
I fff00d93 0
D
E 25 00000008
E 26 00000010
E 27 ffffffff

/* sources.f */
+incdir+.
core_pkg.sv
instr_decode.sv
axil_dispatch_port.sv
rename_table.sv
reorder_buffer.sv
arch_reg_file.sv
issue_queue.sv
alu_unit.sv
ooo_core_top.sv
tb_ooo_core.sv

/* run_sim.sh */
#!/bin/sh
# build with verilator, run, and decide on the pass line in the output.
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f sources.f --top-module tb_ooo_core -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -x "test passed" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

/* tb_ooo_core.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module tb_ooo_core;

    logic                   clk;
    logic                   rstn;
    logic [`AXI_ADDR_W-1:0] awaddr;
    logic                   awvalid;
    logic                   awready;
    logic [`XLEN-1:0]       wdata;
    logic [`XLEN/8-1:0]     wstrb;
    logic                   wvalid;
    logic                   wready;
    logic [1:0]             bresp;
    logic                   bvalid;
    logic                   bready;
    logic [`AXI_ADDR_W-1:0] araddr;
    logic                   arvalid;
    logic                   arready;
    logic [`XLEN-1:0]       rdata;
    logic [1:0]             rresp;
    logic                   rvalid;
    logic                   rready;

    string trace_lines[$];
    int    cycle_count = 0;
    int    cycle_limit = 0;

    ooo_core_top i_ooo_core_top (
        .clk(clk), .rstn(rstn),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
    );

    always #4 clk = ~clk;

    // watchdog on the total run length.
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, the core stopped making progress", cycle_count);
            $display("test failed");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERR %s expected 0x%08h actual 0x%08h", name, expected, actual);
            $display("test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [`AXI_ADDR_W-1:0] reg_addr(input int r);
        return `AXI_ADDR_W'(`ADDR_REG_BASE + 4 * r);
    endfunction

    // aw and w are offered together, bvalid follows the accepting edge.
    task automatic write_instr(input logic [31:0] word, output logic [1:0] resp);
        logic accepted;
        repeat ($urandom_range(3)) @(negedge clk);
        @(negedge clk);
        awaddr  = `ADDR_INSTR;
        awvalid = 1'b1;
        wdata   = word;
        wstrb   = '1;
        wvalid  = 1'b1;
        do begin
            @(posedge clk);
            accepted = awready && wready;
            check("write awready with wready", 32'(awready), 32'(wready));
            @(negedge clk);
            check("write bvalid after accept", 32'(accepted), 32'(bvalid));
        end while (!accepted);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        resp    = bresp;
        while ($urandom_range(3) == 0) begin
            @(negedge clk);
        end
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic read_word(input logic [`AXI_ADDR_W-1:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        logic accepted;
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        do begin
            @(posedge clk);
            accepted = arready;
            @(negedge clk);
            check($sformatf("read 0x%02h rvalid after accept", addr),
                  32'(accepted), 32'(rvalid));
        end while (!accepted);
        arvalid = 1'b0;
        data    = rdata;
        resp    = rresp;
        while ($urandom_range(3) == 0) begin
            @(negedge clk);
        end
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    // poll the in-flight count until everything has retired.
    task automatic drain(input string name);
        logic [31:0] status;
        logic [1:0]  resp;
        do begin
            read_word(`ADDR_STATUS, status, resp);
            check({name, " status rresp"}, 32'd0, 32'(resp));
            check({name, " status within rob depth"}, 32'd1, 32'(status <= `ROB_DEPTH));
        end while (status != 0);
    endtask

    initial begin
        int          fd;
        string       line;
        string       rest;
        string       name;
        logic [31:0] word;
        logic [31:0] value;
        logic [31:0] expected;
        logic [1:0]  resp;
        int          regnum;

        clk     = 1'b0;
        rstn    = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        void'($urandom(94776));

        fd = $fopen("core_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open core_trace.txt for reading");
            $display("test failed");
            $fatal(1, "missing trace file");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line.getc(0) != "#") begin
                trace_lines.push_back(line);
            end
        end
        $fclose(fd);
        // 200 cycles per record, plus room for the reset-state reads.
        cycle_limit = 200 * (trace_lines.size() + 40);

        repeat (10) @(negedge clk);
        rstn = 1'b1;

        check("reset bvalid", 32'd0, 32'(bvalid));
        check("reset rvalid", 32'd0, 32'(rvalid));
        read_word(`ADDR_STATUS, value, resp);
        check("reset status", 32'd0, value);
        for (int r = 0; r < `NUM_ARCH_REGS; r++) begin
            read_word(reg_addr(r), value, resp);
            check($sformatf("reset x%0d rresp", r), 32'd0, 32'(resp));
            check($sformatf("reset x%0d", r), 32'd0, value);
        end
        read_word(8'h40, value, resp);
        check("unmapped read rresp", 32'd2, 32'(resp));
        check("unmapped read data", 32'd0, value);

        foreach (trace_lines[i]) begin
            line = trace_lines[i];
            rest = line.substr(1, line.len() - 1);
            name = $sformatf("record %0d", i + 1);
            case (line.getc(0))
                "I": begin
                    void'($sscanf(rest, "%h %h", word, expected));
                    write_instr(word, resp);
                    check({name, " bresp"}, expected, 32'(resp));
                end
                "D": begin
                    drain(name);
                end
                "E": begin
                    void'($sscanf(rest, "%d %h", regnum, expected));
                    read_word(reg_addr(regnum), value, resp);
                    check({name, " rresp"}, 32'd0, 32'(resp));
                    check($sformatf("%s x%0d", name, regnum), expected, value);
                end
                default: begin
                    $display("unknown record kind in %s of the trace", name);
                    $display("test failed");
                    $fatal(1, "bad trace record");
                end
            endcase
        end

        $display("test passed");
        $finish;
    end

endmodule

/* ooo_core_top.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module ooo_core_top (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [`AXI_ADDR_W-1:0] awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [`XLEN-1:0]       wdata,
    input  logic [`XLEN/8-1:0]     wstrb,
    input  logic                   wvalid,
    output logic                   wready,
    output logic [1:0]             bresp,
    output logic                   bvalid,
    input  logic                   bready,
    input  logic [`AXI_ADDR_W-1:0] araddr,
    input  logic                   arvalid,
    output logic                   arready,
    output logic [`XLEN-1:0]       rdata,
    output logic [1:0]             rresp,
    output logic                   rvalid,
    input  logic                   rready
);
    core_pkg::decoded_instr_t dispatch;
    core_pkg::iq_entry_t      entry;
    core_pkg::iq_entry_t      issue0;
    core_pkg::iq_entry_t      issue1;
    core_pkg::cdb_t           cdb0;
    core_pkg::cdb_t           cdb1;
    core_pkg::retire_t        retire;
    core_pkg::operand_t       rob_val1;
    core_pkg::operand_t       rob_val2;
    logic [`ROB_TAG_W-1:0]    rob_tag;
    logic [`ROB_TAG_W-1:0]    src1_tag;
    logic [`ROB_TAG_W-1:0]    src2_tag;
    logic [`ROB_TAG_W:0]      in_flight;
    logic                     src1_busy;
    logic                     src2_busy;
    logic                     rob_full;
    logic                     iq_full;
    logic [4:0]               reg_rd_addr;
    logic [`XLEN-1:0]         reg_rd_data;
    logic [`XLEN-1:0]         rs1_val;
    logic [`XLEN-1:0]         rs2_val;

    axil_dispatch_port i_axil_dispatch_port (
        .clk(clk), .rstn(rstn),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .dispatch_ready(!rob_full && !iq_full), .in_flight(in_flight),
        .dispatch(dispatch), .reg_rd_addr(reg_rd_addr), .reg_rd_data(reg_rd_data)
    );

    rename_table i_rename_table (
        .clk(clk), .rstn(rstn), .dispatch(dispatch), .dispatch_tag(rob_tag),
        .retire(retire), .src1_busy(src1_busy), .src1_tag(src1_tag),
        .src2_busy(src2_busy), .src2_tag(src2_tag)
    );

    reorder_buffer i_reorder_buffer (
        .clk(clk), .rstn(rstn), .dispatch(dispatch), .dispatch_fire(dispatch.valid),
        .dispatch_tag(rob_tag), .full(rob_full), .in_flight(in_flight),
        .cdb0(cdb0), .cdb1(cdb1), .rd_tag1(src1_tag), .rd_tag2(src2_tag),
        .rd_val1(rob_val1), .rd_val2(rob_val2), .retire(retire)
    );

    arch_reg_file i_arch_reg_file (
        .clk(clk), .rstn(rstn), .retire(retire), .rs1(dispatch.rs1), .rs2(dispatch.rs2),
        .dbg_addr(reg_rd_addr), .rs1_val(rs1_val), .rs2_val(rs2_val), .dbg_val(reg_rd_data)
    );

    // pending sources come from the rob, the rest from the arf or the immediate.
    always_comb begin
        entry.valid = dispatch.valid;
        entry.op    = dispatch.op;
        entry.tag   = rob_tag;
        if (src1_busy) begin
            entry.src1 = rob_val1;
        end else begin
            entry.src1 = '{ready: 1'b1, tag: '0, value: rs1_val};
        end
        if (dispatch.uses_imm) begin
            entry.src2 = '{ready: 1'b1, tag: '0, value: dispatch.imm};
        end else if (src2_busy) begin
            entry.src2 = rob_val2;
        end else begin
            entry.src2 = '{ready: 1'b1, tag: '0, value: rs2_val};
        end
    end

    issue_queue i_issue_queue (
        .clk(clk), .rstn(rstn), .entry_in(entry), .entry_fire(dispatch.valid),
        .full(iq_full), .cdb0(cdb0), .cdb1(cdb1), .issue0(issue0), .issue1(issue1)
    );

    alu_unit i_alu0 (.clk(clk), .rstn(rstn), .issue(issue0), .result(cdb0));
    alu_unit i_alu1 (.clk(clk), .rstn(rstn), .issue(issue1), .result(cdb1));

endmodule

/* alu_unit.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module alu_unit (
    input  logic                clk,
    input  logic                rstn,
    input  core_pkg::iq_entry_t issue,
    output core_pkg::cdb_t      result
);
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [`XLEN-1:0] alu_out;

    assign a = issue.src1.value;
    assign b = issue.src2.value;

    // shift amount is the low 5 bits of b.
    always_comb begin
        case (issue.op)
            core_pkg::ADD:    alu_out = a + b;
            core_pkg::SUB:    alu_out = a - b;
            core_pkg::AND:    alu_out = a & b;
            core_pkg::OR:     alu_out = a | b;
            core_pkg::XOR:    alu_out = a ^ b;
            core_pkg::SLL:    alu_out = a << b[4:0];
            core_pkg::SRL:    alu_out = a >> b[4:0];
            core_pkg::SRA:    alu_out = $signed(a) >>> b[4:0];
            core_pkg::SLT:    alu_out = `XLEN'($signed(a) < $signed(b));
            core_pkg::SLTU:   alu_out = `XLEN'(a < b);
            core_pkg::PASS_B: alu_out = b;
            default:          alu_out = '0;
        endcase
    end

    // one cycle from issue to the bus.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            result.valid <= 1'b0;
        end else begin
            result.valid <= issue.valid;
            result.tag   <= issue.tag;
            result.value <= alu_out;
        end
    end

endmodule

/* issue_queue.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module issue_queue (
    input  logic                clk,
    input  logic                rstn,
    input  core_pkg::iq_entry_t entry_in,
    input  logic                entry_fire,
    output logic                full,
    input  core_pkg::cdb_t      cdb0,
    input  core_pkg::cdb_t      cdb1,
    output core_pkg::iq_entry_t issue0,
    output core_pkg::iq_entry_t issue1
);
    core_pkg::iq_entry_t          entries [`IQ_DEPTH];
    core_pkg::iq_entry_t          picked [`NUM_ALUS];
    logic [`IQ_DEPTH-1:0]         valid_vec;
    logic [`IQ_DEPTH-1:0]         ready_vec;
    logic [`IQ_DEPTH-1:0]         grant;
    logic [$clog2(`IQ_DEPTH)-1:0] free_idx;

    // operand wakeup from one bus port.
    function automatic core_pkg::operand_t wake(input core_pkg::operand_t op,
                                                input core_pkg::cdb_t bus);
        core_pkg::operand_t res;
        res = op;
        if (!op.ready && bus.valid && bus.tag == op.tag) begin
            res.ready = 1'b1;
            res.value = bus.value;
        end
        return res;
    endfunction

    always_comb begin
        free_idx = '0;
        for (int i = `IQ_DEPTH - 1; i >= 0; i--) begin
            valid_vec[i] = entries[i].valid;
            ready_vec[i] = entries[i].valid && entries[i].src1.ready && entries[i].src2.ready;
            if (!entries[i].valid) begin
                free_idx = i[$clog2(`IQ_DEPTH)-1:0];
            end
        end
    end

    assign full = &valid_vec;

    // lowest-index ready entries go out, one per alu.
    always_comb begin
        int n;
        n     = 0;
        grant = '0;
        for (int k = 0; k < `NUM_ALUS; k++) begin
            picked[k] = '0;
        end
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            if (ready_vec[i] && n < `NUM_ALUS) begin
                picked[n] = entries[i];
                grant[i]  = 1'b1;
                n++;
            end
        end
    end

    assign issue0 = picked[0];
    assign issue1 = picked[1];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < `IQ_DEPTH; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            for (int i = 0; i < `IQ_DEPTH; i++) begin
                if (grant[i]) begin
                    entries[i].valid <= 1'b0;
                end else if (entries[i].valid) begin
                    entries[i].src1 <= wake(wake(entries[i].src1, cdb0), cdb1);
                    entries[i].src2 <= wake(wake(entries[i].src2, cdb0), cdb1);
                end
            end
            if (entry_fire) begin
                entries[free_idx] <= entry_in;
            end
        end
    end

endmodule

/* arch_reg_file.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module arch_reg_file (
    input  logic              clk,
    input  logic              rstn,
    input  core_pkg::retire_t retire,
    input  logic [4:0]        rs1,
    input  logic [4:0]        rs2,
    input  logic [4:0]        dbg_addr,
    output logic [`XLEN-1:0]  rs1_val,
    output logic [`XLEN-1:0]  rs2_val,
    output logic [`XLEN-1:0]  dbg_val
);
    logic [`XLEN-1:0] regs [`NUM_ARCH_REGS];

    // x0 is cleared at reset and never written.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < `NUM_ARCH_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (retire.valid && retire.rd != 5'd0) begin
            regs[retire.rd] <= retire.value;
        end
    end

    assign rs1_val = regs[rs1];
    assign rs2_val = regs[rs2];
    assign dbg_val = regs[dbg_addr];

endmodule

/* reorder_buffer.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module reorder_buffer (
    input  logic                     clk,
    input  logic                     rstn,
    input  core_pkg::decoded_instr_t dispatch,
    input  logic                     dispatch_fire,
    output logic [`ROB_TAG_W-1:0]    dispatch_tag,
    output logic                     full,
    output logic [`ROB_TAG_W:0]      in_flight,
    input  core_pkg::cdb_t           cdb0,
    input  core_pkg::cdb_t           cdb1,
    input  logic [`ROB_TAG_W-1:0]    rd_tag1,
    input  logic [`ROB_TAG_W-1:0]    rd_tag2,
    output core_pkg::operand_t       rd_val1,
    output core_pkg::operand_t       rd_val2,
    output core_pkg::retire_t        retire
);
    logic [`ROB_TAG_W-1:0] head;
    logic [`ROB_TAG_W-1:0] tail;
    logic [`ROB_TAG_W:0]   count;
    logic [`ROB_DEPTH-1:0] done;
    logic [`ROB_DEPTH-1:0] writes_rd_q;
    logic [4:0]            rd_q [`ROB_DEPTH];
    logic [`XLEN-1:0]      value_q [`ROB_DEPTH];

    // completed entry first, then a same-cycle bus hit.
    function automatic core_pkg::operand_t resolve(input logic [`ROB_TAG_W-1:0] tag);
        core_pkg::operand_t res;
        res.tag   = tag;
        res.ready = 1'b1;
        res.value = '0;
        if (done[tag]) begin
            res.value = value_q[tag];
        end else if (cdb0.valid && cdb0.tag == tag) begin
            res.value = cdb0.value;
        end else if (cdb1.valid && cdb1.tag == tag) begin
            res.value = cdb1.value;
        end else begin
            res.ready = 1'b0;
        end
        return res;
    endfunction

    always_comb begin
        rd_val1 = resolve(rd_tag1);
        rd_val2 = resolve(rd_tag2);
    end

    assign dispatch_tag = tail;
    assign full         = (count == `ROB_DEPTH);
    assign in_flight    = count;

    // head retires once done, at most one per cycle.
    always_comb begin
        retire.valid = (count != '0) && done[head];
        retire.rd    = writes_rd_q[head] ? rd_q[head] : 5'd0;
        retire.tag   = head;
        retire.value = value_q[head];
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            done  <= '0;
        end else begin
            if (dispatch_fire) begin
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1;
            end
            if (cdb0.valid) begin
                done[cdb0.tag] <= 1'b1;
            end
            if (cdb1.valid) begin
                done[cdb1.tag] <= 1'b1;
            end
            if (retire.valid) begin
                head <= head + 1'b1;
            end
            if (dispatch_fire && !retire.valid) begin
                count <= count + 1'b1;
            end else if (!dispatch_fire && retire.valid) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch_fire) begin
            rd_q[tail]        <= dispatch.rd;
            writes_rd_q[tail] <= dispatch.writes_rd;
        end
        if (cdb0.valid) begin
            value_q[cdb0.tag] <= cdb0.value;
        end
        if (cdb1.valid) begin
            value_q[cdb1.tag] <= cdb1.value;
        end
    end

endmodule

/* rename_table.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module rename_table (
    input  logic                     clk,
    input  logic                     rstn,
    input  core_pkg::decoded_instr_t dispatch,
    input  logic [`ROB_TAG_W-1:0]    dispatch_tag,
    input  core_pkg::retire_t        retire,
    output logic                     src1_busy,
    output logic [`ROB_TAG_W-1:0]    src1_tag,
    output logic                     src2_busy,
    output logic [`ROB_TAG_W-1:0]    src2_tag
);
    logic [`NUM_ARCH_REGS-1:0] busy;
    logic [`ROB_TAG_W-1:0]     tags [`NUM_ARCH_REGS];
    logic                      set_en;
    logic                      clr_en;

    // writes_rd is already low for x0.
    assign set_en = dispatch.valid && dispatch.writes_rd;
    // only the current writer of the register clears the mapping.
    assign clr_en = retire.valid && busy[retire.rd] && (tags[retire.rd] == retire.tag);

    // the set comes last, so dispatch wins over retirement of the same register.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy <= '0;
        end else begin
            if (clr_en) begin
                busy[retire.rd] <= 1'b0;
            end
            if (set_en) begin
                busy[dispatch.rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (set_en) begin
            tags[dispatch.rd] <= dispatch_tag;
        end
    end

    assign src1_busy = busy[dispatch.rs1];
    assign src1_tag  = tags[dispatch.rs1];
    assign src2_busy = busy[dispatch.rs2] && dispatch.uses_rs2;
    assign src2_tag  = tags[dispatch.rs2];

endmodule

/* axil_dispatch_port.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module axil_dispatch_port (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic [`AXI_ADDR_W-1:0]      awaddr,
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [`XLEN-1:0]            wdata,
    input  logic [`XLEN/8-1:0]          wstrb,
    input  logic                        wvalid,
    output logic                        wready,
    output logic [1:0]                  bresp,
    output logic                        bvalid,
    input  logic                        bready,
    input  logic [`AXI_ADDR_W-1:0]      araddr,
    input  logic                        arvalid,
    output logic                        arready,
    output logic [`XLEN-1:0]            rdata,
    output logic [1:0]                  rresp,
    output logic                        rvalid,
    input  logic                        rready,
    input  logic                        dispatch_ready,
    input  logic [`ROB_TAG_W:0]         in_flight,
    output core_pkg::decoded_instr_t    dispatch,
    output logic [4:0]                  reg_rd_addr,
    input  logic [`XLEN-1:0]            reg_rd_data
);
    core_pkg::decoded_instr_t decoded;
    core_pkg::axil_state_e    rd_state;
    logic                     wr_fire;
    logic                     instr_write;
    logic                     rd_fire;
    logic                     in_window;
    logic [`AXI_ADDR_W-1:0]   reg_off;

    instr_decode i_instr_decode (
        .instr   (wdata),
        .decoded (decoded)
    );

    // both write channels together, only with room in the rob and queue.
    assign wr_fire     = awvalid && wvalid && !bvalid && dispatch_ready;
    assign awready     = wr_fire;
    assign wready      = wr_fire;
    assign instr_write = (awaddr == `ADDR_INSTR) && (wstrb == '1);

    always_comb begin
        dispatch       = decoded;
        dispatch.valid = decoded.valid && wr_fire && instr_write;
    end

    // bresp is OKAY (00) or SLVERR (10).
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            bvalid <= 1'b0;
            bresp  <= 2'b00;
        end else if (wr_fire) begin
            bvalid <= 1'b1;
            bresp  <= (instr_write && decoded.valid) ? 2'b00 : 2'b10;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    assign rd_fire     = arvalid && (rd_state == core_pkg::IDLE);
    assign arready     = rd_fire;
    assign rvalid      = (rd_state == core_pkg::RESP);
    assign reg_off     = araddr - `ADDR_REG_BASE;
    assign in_window   = (araddr >= `ADDR_REG_BASE) && (reg_off < 4 * `NUM_ARCH_REGS);
    assign reg_rd_addr = reg_off[6:2];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rd_state <= core_pkg::IDLE;
        end else if (rd_fire) begin
            rd_state <= core_pkg::RESP;
        end else if (rready) begin
            rd_state <= core_pkg::IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rresp <= 2'b00;
            if (araddr == `ADDR_STATUS) begin
                rdata <= `XLEN'(in_flight);
            end else if (in_window) begin
                rdata <= reg_rd_data;
            end else begin
                rdata <= '0;
                rresp <= 2'b10;
            end
        end
    end

endmodule

/* instr_decode.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module instr_decode (
    input  logic [`XLEN-1:0]         instr,
    output core_pkg::decoded_instr_t decoded
);
    logic [6:0]        opcode;
    logic [6:0]        funct7;
    logic [2:0]        funct3;
    logic              is_op;
    logic              is_imm;
    logic              is_lui;
    logic              f7_zero;
    logic              f7_alt;
    core_pkg::alu_op_e f3_op;

    assign opcode  = instr[6:0];
    assign funct3  = instr[14:12];
    assign funct7  = instr[31:25];
    assign is_op   = (opcode == 7'b0110011);
    assign is_imm  = (opcode == 7'b0010011);
    assign is_lui  = (opcode == 7'b0110111);
    assign f7_zero = (funct7 == 7'b0000000);
    assign f7_alt  = (funct7 == 7'b0100000);

    // funct3 selects the operation, bit 30 picks sub and sra.
    always_comb begin
        case (funct3)
            3'b000:  f3_op = (is_op && f7_alt) ? core_pkg::SUB : core_pkg::ADD;
            3'b001:  f3_op = core_pkg::SLL;
            3'b010:  f3_op = core_pkg::SLT;
            3'b011:  f3_op = core_pkg::SLTU;
            3'b100:  f3_op = core_pkg::XOR;
            3'b101:  f3_op = f7_alt ? core_pkg::SRA : core_pkg::SRL;
            3'b110:  f3_op = core_pkg::OR;
            default: f3_op = core_pkg::AND;
        endcase
    end

    always_comb begin
        decoded          = '0;
        decoded.rd       = instr[11:7];
        decoded.op       = f3_op;
        decoded.uses_rs2 = is_op;
        decoded.uses_imm = is_imm || is_lui;
        decoded.rs1      = is_lui ? 5'd0 : instr[19:15];
        decoded.rs2      = is_op ? instr[24:20] : 5'd0;
        if (is_lui) begin
            decoded.op  = core_pkg::PASS_B;
            decoded.imm = {instr[31:12], 12'b0};
        end else begin
            decoded.imm = {{(`XLEN-12){instr[31]}}, instr[31:20]};
        end
        // only add/sub and the right shifts allow the alternate funct7.
        if (is_op) begin
            decoded.illegal = !(f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101)));
        end else if (is_imm) begin
            decoded.illegal = (funct3 == 3'b001 && !f7_zero) ||
                              (funct3 == 3'b101 && !(f7_zero || f7_alt));
        end else begin
            decoded.illegal = !is_lui;
        end
        decoded.valid     = !decoded.illegal;
        decoded.writes_rd = !decoded.illegal && (decoded.rd != 5'd0);
    end

endmodule

/* core_pkg.sv */
`include "core_settings.svh"

package core_pkg;

    // alu operations, PASS_B forwards operand b for lui.
    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU, PASS_B
    } alu_op_e;

    // read channel state of the axi port.
    typedef enum logic {
        IDLE,
        RESP
    } axil_state_e;

    typedef struct packed {
        logic             valid;
        logic             illegal;
        alu_op_e          op;
        logic [4:0]       rs1;
        logic [4:0]       rs2;
        logic [4:0]       rd;
        logic             uses_rs2;
        logic             uses_imm;
        logic [`XLEN-1:0] imm;
        logic             writes_rd;
    } decoded_instr_t;

    // source operand, tag is meaningful only while not ready.
    typedef struct packed {
        logic                  ready;
        logic [`ROB_TAG_W-1:0] tag;
        logic [`XLEN-1:0]      value;
    } operand_t;

    typedef struct packed {
        logic                  valid;
        alu_op_e               op;
        operand_t              src1;
        operand_t              src2;
        logic [`ROB_TAG_W-1:0] tag;
    } iq_entry_t;

    typedef struct packed {
        logic                  valid;
        logic [`ROB_TAG_W-1:0] tag;
        logic [`XLEN-1:0]      value;
    } cdb_t;

    typedef struct packed {
        logic                  valid;
        logic [4:0]            rd;
        logic [`ROB_TAG_W-1:0] tag;
        logic [`XLEN-1:0]      value;
    } retire_t;

endpackage

/* core_settings.svh */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// datapath and architectural state.
`define XLEN          32
`define NUM_ARCH_REGS 32

// out-of-order resources.
`define ROB_DEPTH 8
`define ROB_TAG_W 3
`define IQ_DEPTH  4
`define NUM_ALUS  2

// axi4-lite address map, 4 bytes per register in the window.
`define AXI_ADDR_W    8
`define ADDR_INSTR    8'h00
`define ADDR_STATUS   8'h04
`define ADDR_REG_BASE 8'h80

`endif
